// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - source/decode_pkg.sv
  - source/decode_imm.sv
  - source/decode_uop.sv
  - source/decode_pc.sv
  - source/decode_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_decode_stage.sv

// ==== decode_stage.f ====
source/decode_pkg.sv
source/decode_imm.sv
source/decode_uop.sv
source/decode_pc.sv
source/decode_stage.sv
+incdir+testbench
testbench/tb_decode_stage.sv

// ==== source/decode_imm.sv ====
/*
 * Immediate decoder. Builds the I, S, B, U and J immediates and the
 * shift amount, then picks one by major opcode.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_imm (
    input  decode_pkg::instr_t instr_i,             // Instruction word
    output decode_pkg::word_t  imm_o                // Selected immediate
);

    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_shift;                           // SLLI, SRLI, SRAI

    word_t imm_i_fmt;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    word_t imm_shamt;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign is_shift = (funct3 == 3'd1) || (funct3 == 3'd5);

    // ----------------------------------------------------------
    // Format extraction
    // ----------------------------------------------------------

    assign imm_i_fmt = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s     = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b     = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u     = {instr_i[31:12], 12'b0};
    assign imm_j     = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
    assign imm_shamt = {{(XLEN-5){1'b0}}, instr_i[24:20]};   // Zero extended

    always_comb begin
        case (opcode)
            OPC_BRANCH:         imm_o = imm_b;
            OPC_LUI, OPC_AUIPC: imm_o = imm_u;
            OPC_JAL:            imm_o = imm_j;
            OPC_STORE:          imm_o = imm_s;
            OPC_OP_IMM:         imm_o = is_shift ? imm_shamt : imm_i_fmt;
            OPC_JALR, OPC_LOAD: imm_o = imm_i_fmt;
            default:            imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/decode_pc.sv ====
/*
 * Program counter of the decode stage. Next-PC, redirect from execute
 * and the fetch/issue valid-ready handshake.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_pc (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  fetch_valid_i,    // Instruction present
    input  logic                  issue_ready_i,    // Execute can take it
    input  decode_pkg::redirect_t redirect_i,       // Control flow change
    output logic                  fetch_accept_o,   // Instruction consumed
    output logic                  issue_valid_o,
    output decode_pkg::word_t     pc_o,
    output decode_pkg::word_t     npc_o
);

    import decode_pkg::*;

    word_t pc_q;

    assign issue_valid_o  = fetch_valid_i;
    assign fetch_accept_o = fetch_valid_i && issue_ready_i;

    assign pc_o  = pc_q;
    assign npc_o = pc_q + XLEN'(4);                 // RV32I only, no compressed

    // Redirect wins over a concurrent accept
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_ADDR;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.target;
        end else if (fetch_accept_o) begin
            pc_q <= npc_o;
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    a_redirect_aligned: assert property (@(posedge g_clk) disable iff (!g_resetn)
        redirect_i.valid |-> (redirect_i.target[1:0] == 2'b00));

    a_accept_valid: assert property (@(posedge g_clk) disable iff (!g_resetn)
        fetch_accept_o |-> fetch_valid_i);

endmodule

`default_nettype wire

// ==== source/decode_pkg.sv ====
/*
 * Shared definitions for the RV32I decode stage. Widths, vector types,
 * major opcodes, trap causes and the packed micro-op structs.
 */
`default_nettype none

package decode_pkg;

    localparam int XLEN = 32;                       // Datapath width

    // Vector types
    typedef logic [XLEN-1:0] word_t;                // One data word
    typedef logic [31:0]     instr_t;               // One instruction word
    typedef logic [4:0]      reg_addr_t;            // Register index
    typedef logic [6:0]      trap_cause_t;          // Trap cause code

    localparam word_t PC_RESET_ADDR = 32'h1000_0000; // PC after reset

    // Major opcodes, bits 6:0 of the instruction
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam trap_cause_t TRAP_IACCESS = 7'd1;    // Instruction access fault
    localparam trap_cause_t TRAP_IOPCODE = 7'd2;    // Illegal instruction

    // ----------------------------------------------------------
    // Operation groups, one flag per operation
    // ----------------------------------------------------------

    typedef struct packed {
        logic add, sub, and_, or_, xor_, sll, srl, sra, slt, sltu;
    } alu_op_t;

    typedef struct packed {
        logic beq, bne, blt, bge, bltu, bgeu, jal, jalr;
    } cfu_op_t;

    typedef struct packed {
        logic load, store, byte_, half, word, sext;
    } lsu_op_t;

    typedef struct packed {
        logic alu, lsu, npc;                        // Writeback source
    } wb_sel_t;

    typedef struct packed {
        logic  valid;                               // Take the target
        word_t target;
    } redirect_t;

    // Micro-op handed to execute
    typedef struct packed {
        alu_op_t     alu;
        cfu_op_t     cfu;
        lsu_op_t     lsu;
        wb_sel_t     wb;
        reg_addr_t   rd;
        reg_addr_t   rs1_addr;
        reg_addr_t   rs2_addr;
        word_t       rs1_data;
        word_t       rs2_data;
        word_t       imm;
        word_t       alu_lhs;
        word_t       alu_rhs;
        word_t       pc;
        word_t       npc;
        logic        trap;
        trap_cause_t trap_cause;
    } uop_t;

endpackage

`default_nettype wire

// ==== source/decode_stage.sv ====
/*
 * Decode and operand-gather stage, top level.
 * PC tracking, immediate decoder and micro-op decoder.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                  g_clk,            // Global clock
    input  logic                  g_resetn,         // Sync reset, active low

    input  logic                  fetch_valid_i,
    input  decode_pkg::instr_t    fetch_instr_i,    // Instruction to decode
    input  logic [1:0]            fetch_err_i,      // Fetch bus error
    output logic                  fetch_accept_o,

    input  decode_pkg::redirect_t redirect_i,       // From execute

    output decode_pkg::reg_addr_t rs1_addr_o,
    input  decode_pkg::word_t     rs1_data_i,       // Forwarded
    output decode_pkg::reg_addr_t rs2_addr_o,
    input  decode_pkg::word_t     rs2_data_i,       // Forwarded

    output logic                  issue_valid_o,
    input  logic                  issue_ready_i,
    output decode_pkg::uop_t      issue_o           // Micro-op to execute
);

    import decode_pkg::*;

    word_t pc;
    word_t npc;
    word_t imm;

    decode_pc u_pc (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .fetch_valid_i  (fetch_valid_i),
        .issue_ready_i  (issue_ready_i),
        .redirect_i     (redirect_i),
        .fetch_accept_o (fetch_accept_o),
        .issue_valid_o  (issue_valid_o),
        .pc_o           (pc),
        .npc_o          (npc)
    );

    decode_imm u_imm (
        .instr_i (fetch_instr_i),
        .imm_o   (imm)
    );

    decode_uop u_uop (
        .instr_i     (fetch_instr_i),
        .fetch_err_i (fetch_err_i),
        .imm_i       (imm),
        .pc_i        (pc),
        .npc_i       (npc),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .rs1_addr_o  (rs1_addr_o),
        .rs2_addr_o  (rs2_addr_o),
        .uop_o       (issue_o)
    );

endmodule

`default_nettype wire

// ==== source/decode_uop.sv ====
/*
 * Micro-op decoder. Register addresses, ALU, branch and load/store flags,
 * writeback source, ALU operands and the two trap causes.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_uop (
    input  decode_pkg::instr_t    instr_i,          // Instruction word
    input  logic [1:0]            fetch_err_i,      // Fetch error per half-word
    input  decode_pkg::word_t     imm_i,            // Selected immediate
    input  decode_pkg::word_t     pc_i,
    input  decode_pkg::word_t     npc_i,
    input  decode_pkg::word_t     rs1_data_i,       // Forwarded read data
    input  decode_pkg::word_t     rs2_data_i,
    output decode_pkg::reg_addr_t rs1_addr_o,
    output decode_pkg::reg_addr_t rs2_addr_o,
    output decode_pkg::uop_t      uop_o
);

    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [7:0] f3_hot;                             // One-hot funct3

    logic is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic is_load, is_store, is_op_imm, is_op;
    logic op_legal, op_imm_legal, legal, illegal, fetch_fault;

    alu_op_t alu;
    cfu_op_t cfu;
    lsu_op_t lsu;
    wb_sel_t wb;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign f3_hot = 8'b1 << funct3;

    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_op     = (opcode == OPC_OP);

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    // ----------------------------------------------------------
    // Operation flags
    // ----------------------------------------------------------

    always_comb begin
        alu = '0;
        if (is_op || is_op_imm) begin
            alu.add  = f3_hot[0] && !(is_op && instr_i[30]);
            alu.sub  = f3_hot[0] && is_op && instr_i[30];  // No SUBI
            alu.sll  = f3_hot[1];
            alu.slt  = f3_hot[2];
            alu.sltu = f3_hot[3];
            alu.xor_ = f3_hot[4];
            alu.srl  = f3_hot[5] && !instr_i[30];
            alu.sra  = f3_hot[5] && instr_i[30];
            alu.or_  = f3_hot[6];
            alu.and_ = f3_hot[7];
        end
        alu.add = alu.add || is_auipc;
        alu.or_ = alu.or_ || is_lui;                // LUI is 0 | imm
        alu.sub = alu.sub || is_branch;             // Compare by subtract
    end

    assign cfu.beq  = is_branch && f3_hot[0];
    assign cfu.bne  = is_branch && f3_hot[1];
    assign cfu.blt  = is_branch && f3_hot[4];
    assign cfu.bge  = is_branch && f3_hot[5];
    assign cfu.bltu = is_branch && f3_hot[6];
    assign cfu.bgeu = is_branch && f3_hot[7];
    assign cfu.jal  = is_jal;
    assign cfu.jalr = is_jalr;

    assign lsu.load  = is_load;
    assign lsu.store = is_store;
    assign lsu.byte_ = (is_load || is_store) && (funct3[1:0] == 2'b00);
    assign lsu.half  = (is_load || is_store) && (funct3[1:0] == 2'b01);
    assign lsu.word  = (is_load || is_store) && (funct3[1:0] == 2'b10);
    assign lsu.sext  = is_load && !funct3[2];       // LB, LH, LW

    assign wb.npc = is_jal || is_jalr;
    assign wb.lsu = is_load;
    assign wb.alu = (|alu) && !is_branch;

    // ----------------------------------------------------------
    // Traps
    // ----------------------------------------------------------

    // Only ADD/SUB and SRL/SRA may carry funct7 0100000
    assign op_legal     = (funct7 == 7'h00) ||
                          ((f3_hot[0] || f3_hot[5]) && (funct7 == 7'h20));
    assign op_imm_legal = !(f3_hot[1] || f3_hot[5]) || (funct7 == 7'h00) ||
                          (f3_hot[5] && (funct7 == 7'h20));

    assign legal = is_lui || is_auipc || is_jal ||
                   (is_jalr   && f3_hot[0]) ||
                   (is_branch && !f3_hot[2] && !f3_hot[3]) ||
                   (is_load   && !f3_hot[3] && !f3_hot[6] && !f3_hot[7]) ||
                   (is_store  && !funct3[2] && (funct3[1:0] != 2'b11)) ||
                   (is_op_imm && op_imm_legal) ||
                   (is_op     && op_legal);

    assign illegal     = (instr_i[1:0] != 2'b11) || !legal;
    assign fetch_fault = |fetch_err_i;              // Either half-word

    always_comb begin
        uop_o            = '0;
        uop_o.alu        = alu;
        uop_o.cfu        = cfu;
        uop_o.lsu        = lsu;
        uop_o.wb         = wb;
        uop_o.rd         = (is_store || is_branch) ? '0 : instr_i[11:7];
        uop_o.rs1_addr   = rs1_addr_o;
        uop_o.rs2_addr   = rs2_addr_o;
        uop_o.rs1_data   = rs1_data_i;
        uop_o.rs2_data   = rs2_data_i;
        uop_o.imm        = imm_i;
        uop_o.alu_lhs    = is_auipc ? pc_i : (is_lui ? '0 : rs1_data_i);
        uop_o.alu_rhs    = (is_op_imm || is_lui || is_auipc || is_load || is_store) ?
                           imm_i : rs2_data_i;
        uop_o.pc         = pc_i;
        uop_o.npc        = npc_i;
        uop_o.trap       = fetch_fault || illegal;
        uop_o.trap_cause = fetch_fault ? TRAP_IACCESS :
                           illegal     ? TRAP_IOPCODE : '0;
    end

    // Execute relies on a single operation and a single result source
    always_comb begin
        assert final ($onehot0(uop_o.alu));
        assert final ($onehot0(uop_o.wb));
    end

endmodule

`default_nettype wire

// ==== testbench/decode_model.svh ====
/*
 * Reference model of the RV32I decode stage. Legality rules for the
 * supported encodings and the expected micro-op for one instruction.
 */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// RV32I without SYSTEM, FENCE and the M extension
function automatic logic encoding_is_legal(instr_t w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    if (w[1:0] != 2'b11) begin
        return 1'b0;
    end
    case (w[6:0])
        OPC_LUI, OPC_AUIPC, OPC_JAL: return 1'b1;
        OPC_JALR:   return f3 == 3'd0;
        OPC_BRANCH: return (f3 != 3'd2) && (f3 != 3'd3);
        OPC_LOAD:   return f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        OPC_STORE:  return f3 inside {3'd0, 3'd1, 3'd2};
        OPC_OP_IMM: begin
            if (f3 == 3'd1) return f7 == 7'h00;                 // SLLI
            if (f3 == 3'd5) return (f7 == 7'h00) || (f7 == 7'h20);
            return 1'b1;
        end
        OPC_OP:     return (f7 == 7'h00) ||
                           ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        default:    return 1'b0;
    endcase
endfunction

function automatic uop_t model_decode(instr_t w, logic [1:0] err, word_t pc,
                                      word_t rs1, word_t rs2);
    uop_t       u;
    logic [6:0] opc;
    logic [2:0] f3;
    word_t      imm_i;
    opc   = w[6:0];
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    u     = '0;

    case (opc)
        OPC_LUI, OPC_AUIPC: u.imm = {w[31:12], 12'h000};
        OPC_JAL:            u.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        OPC_JALR, OPC_LOAD: u.imm = imm_i;
        OPC_BRANCH:         u.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        OPC_STORE:          u.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        OPC_OP_IMM:         u.imm = ((f3 == 3'd1) || (f3 == 3'd5)) ? {27'd0, w[24:20]} : imm_i;
        default:            u.imm = '0;
    endcase

    if ((opc == OPC_OP) || (opc == OPC_OP_IMM)) begin
        case (f3)
            3'd0: begin
                u.alu.sub = (opc == OPC_OP) && w[30];         // No SUBI in RV32I
                u.alu.add = !u.alu.sub;
            end
            3'd1: u.alu.sll  = 1'b1;
            3'd2: u.alu.slt  = 1'b1;
            3'd3: u.alu.sltu = 1'b1;
            3'd4: u.alu.xor_ = 1'b1;
            3'd5: begin
                u.alu.sra = w[30];
                u.alu.srl = !w[30];
            end
            3'd6: u.alu.or_  = 1'b1;
            default: u.alu.and_ = 1'b1;
        endcase
    end
    u.alu.add = u.alu.add || (opc == OPC_AUIPC);
    u.alu.or_ = u.alu.or_ || (opc == OPC_LUI);
    u.alu.sub = u.alu.sub || (opc == OPC_BRANCH);

    if (opc == OPC_BRANCH) begin
        u.cfu.beq  = (f3 == 3'd0);
        u.cfu.bne  = (f3 == 3'd1);
        u.cfu.blt  = (f3 == 3'd4);
        u.cfu.bge  = (f3 == 3'd5);
        u.cfu.bltu = (f3 == 3'd6);
        u.cfu.bgeu = (f3 == 3'd7);
    end
    u.cfu.jal  = (opc == OPC_JAL);
    u.cfu.jalr = (opc == OPC_JALR);

    if ((opc == OPC_LOAD) || (opc == OPC_STORE)) begin
        u.lsu.load  = (opc == OPC_LOAD);
        u.lsu.store = (opc == OPC_STORE);
        u.lsu.byte_ = (f3[1:0] == 2'd0);
        u.lsu.half  = (f3[1:0] == 2'd1);
        u.lsu.word  = (f3[1:0] == 2'd2);
        u.lsu.sext  = (opc == OPC_LOAD) && !f3[2];             // LB, LH, LW
    end

    u.wb.npc = u.cfu.jal || u.cfu.jalr;
    u.wb.lsu = (opc == OPC_LOAD);
    u.wb.alu = (u.alu != '0) && (opc != OPC_BRANCH);

    u.rd       = ((opc == OPC_STORE) || (opc == OPC_BRANCH)) ? 5'd0 : w[11:7];
    u.rs1_addr = w[19:15];
    u.rs2_addr = w[24:20];
    u.rs1_data = rs1;
    u.rs2_data = rs2;
    u.alu_lhs  = (opc == OPC_AUIPC) ? pc : ((opc == OPC_LUI) ? 32'd0 : rs1);
    u.alu_rhs  = (opc inside {OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_LOAD, OPC_STORE}) ?
                 u.imm : rs2;
    u.pc       = pc;
    u.npc      = pc + 32'd4;

    if (err != 2'b00) begin                                     // Access fault first
        u.trap       = 1'b1;
        u.trap_cause = TRAP_IACCESS;
    end else if (!encoding_is_legal(w)) begin
        u.trap       = 1'b1;
        u.trap_cause = TRAP_IOPCODE;
    end
    return u;
endfunction

`endif

// ==== testbench/tb_decode_stage.sv ====
/*
 * Testbench for the decode stage. Clock and reset, LFSR stimulus,
 * register-file model, reference PC and the output checks.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    import decode_pkg::*;

    localparam int NUM_INSTR      = 600;
    localparam int ACCEPT_TIMEOUT = 64;                 // Cycles per instruction
    localparam int RESET_TIMEOUT  = 20;
    localparam logic [62:0] OPCODE_TABLE = {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
        OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};

    logic        g_clk;
    logic        g_resetn;
    logic        fetch_valid_i;
    instr_t      fetch_instr_i;
    logic [1:0]  fetch_err_i;
    logic        fetch_accept_o;
    redirect_t   redirect_i;
    reg_addr_t   rs1_addr_o;
    reg_addr_t   rs2_addr_o;
    word_t       rs1_data_i;
    word_t       rs2_data_i;
    logic        issue_valid_o;
    logic        issue_ready_i;
    uop_t        issue_o;

    word_t       regs [32];                             // Register-file model
    word_t       model_pc;
    uop_t        exp_uop;
    logic [31:0] lfsr;
    int          cyc;

    `include "decode_model.svh"

    decode_stage dut (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_instr_i  (fetch_instr_i),
        .fetch_err_i    (fetch_err_i),
        .fetch_accept_o (fetch_accept_o),
        .redirect_i     (redirect_i),
        .rs1_addr_o     (rs1_addr_o),
        .rs1_data_i     (rs1_data_i),
        .rs2_addr_o     (rs2_addr_o),
        .rs2_data_i     (rs2_data_i),
        .issue_valid_o  (issue_valid_o),
        .issue_ready_i  (issue_ready_i),
        .issue_o        (issue_o)
    );

    assign rs1_data_i = regs[rs1_addr_o];               // Forwarded read, same cycle
    assign rs2_data_i = regs[rs2_addr_o];

    // ----------------------------------------------------------
    // Random numbers and stimulus
    // ----------------------------------------------------------

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(int count);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < count; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic instr_t legal_instr();
        instr_t     w;
        logic [2:0] f3;
        int         idx;
        w      = rand_bits(32);
        f3     = w[14:12];
        idx    = rand_bits(4) % 9;
        w[6:0] = OPCODE_TABLE[7*idx +: 7];
        case (w[6:0])
            OPC_JALR:   w[14:12] = 3'd0;
            OPC_BRANCH: if (f3[2:1] == 2'b01) w[14] = 1'b1;     // 2, 3 become 6, 7
            OPC_LOAD: begin
                if (f3[1:0] == 2'b11) w[12] = 1'b0;
                if (f3[2]) w[13] = 1'b0;                        // LBU, LHU only
            end
            OPC_STORE: begin
                w[14] = 1'b0;
                if (w[13:12] == 2'b11) w[12] = 1'b0;
            end
            OPC_OP_IMM: begin
                if (f3 == 3'd1) w[31:25] = 7'h00;
                if (f3 == 3'd5) w[31:25] = {1'b0, w[30], 5'b0};
            end
            OPC_OP:  w[31:25] = ((f3 == 3'd0) || (f3 == 3'd5)) ? {1'b0, w[30], 5'b0} : 7'h00;
            default: ;
        endcase
        return w;
    endfunction

    task automatic drive_handshake();
        redirect_t rdr;
        word_t     tgt;
        rdr.valid     = (rand_bits(3) == 0);
        tgt           = rand_bits(30);
        rdr.target    = tgt << 2;                       // Word aligned
        fetch_valid_i <= (rand_bits(2) != 0);
        issue_ready_i <= (rand_bits(1) != 0);
        redirect_i    <= rdr;
    endtask

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_value(string what, logic [$bits(uop_t)-1:0] got,
                                 logic [$bits(uop_t)-1:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Checked on the falling edge, after the handshake values settle
    task automatic wait_accept();
        int waited;
        waited = 0;
        @(negedge g_clk);
        while (fetch_accept_o !== 1'b1) begin
            if (waited == ACCEPT_TIMEOUT) begin
                $display("Timeout: instruction was not accepted after %0d cycles", waited);
                abort_run();
            end
            @(posedge g_clk);
            drive_handshake();
            @(negedge g_clk);
            waited++;
        end
    endtask

    // ----------------------------------------------------------
    // Clock, reset, reference PC and checks
    // ----------------------------------------------------------

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;                     // 40 ns period
    end

    initial begin
        g_resetn = 1'b0;
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;
    end

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            model_pc <= PC_RESET_ADDR;
        end else if (redirect_i.valid) begin
            model_pc <= redirect_i.target;              // Redirect beats accept
        end else if (fetch_valid_i && issue_ready_i) begin
            model_pc <= model_pc + 32'd4;
        end
    end

    always @(negedge g_clk) begin
        if (g_resetn) begin
            exp_uop = model_decode(fetch_instr_i, fetch_err_i, model_pc,
                                   regs[fetch_instr_i[19:15]], regs[fetch_instr_i[24:20]]);
            compare_value("issue_o", issue_o, exp_uop);
            compare_value("issue_valid_o", issue_valid_o, fetch_valid_i);
            compare_value("fetch_accept_o", fetch_accept_o, fetch_valid_i && issue_ready_i);
            compare_value("rs1_addr_o", rs1_addr_o, fetch_instr_i[19:15]);
            compare_value("rs2_addr_o", rs2_addr_o, fetch_instr_i[24:20]);
        end
    end

    initial begin
        lfsr          = 32'd79247;
        fetch_valid_i = 1'b0;
        fetch_instr_i = '0;
        fetch_err_i   = 2'b00;
        issue_ready_i = 1'b0;
        redirect_i    = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = (i == 0) ? 32'd0 : 32'h9E37_79B9 * i;     // x0 reads zero
        end

        cyc = 0;
        while (g_resetn !== 1'b1) begin
            if (cyc == RESET_TIMEOUT) begin
                $display("Timeout: reset was never released");
                abort_run();
            end
            @(posedge g_clk);
            cyc++;
        end

        for (int n = 0; n < NUM_INSTR; n++) begin
            @(posedge g_clk);
            fetch_instr_i <= (rand_bits(2) != 0) ? legal_instr() : rand_bits(32);
            fetch_err_i   <= (rand_bits(3) == 0) ? 2'(rand_bits(2)) : 2'b00;
            drive_handshake();
            wait_accept();
        end
        @(negedge g_clk);
        @(posedge g_clk);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
